//--- all.f
logic/flash_geom_pkg.sv
logic/flash_mp_pkg.sv
logic/flash_ifs.sv
logic/flash_op_fsm.sv
logic/flash_addr_cnt.sv
logic/flash_mp_region_sel.sv
logic/flash_mp.sv
logic/flash_array.sv
logic/flash_prot_top.sv
verif/tb_clk_gen.sv
verif/flash_prot_tb.sv

//--- run.sh
#!/bin/sh
# builds the flash protection testbench with Verilator and runs it
# the exit status is the simulator's, nonzero when the run fails
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module flash_prot_tb -f all.f \
  -o Vflash_prot_tb &&
./obj_dir/Vflash_prot_tb ||
exit 1

//--- verif/flash_prot_tb.sv
// testbench for the protected flash slice
// fixed protection setup, command table applied in a loop,
// typed compare tasks and a cycle limit
`timescale 1ns/1ps
`default_nettype none

module flash_prot_tb;

  // region 2 opens bank 1 pages 0-3 so that a bank erase can be read back
  localparam int MpRegions = 3;

  localparam flash_mp_pkg::flash_op_e     Rd     = flash_mp_pkg::OpRead;
  localparam flash_mp_pkg::flash_op_e     Pg     = flash_mp_pkg::OpProg;
  localparam flash_mp_pkg::flash_op_e     PgEr   = flash_mp_pkg::OpPageErase;
  localparam flash_mp_pkg::flash_op_e     BkEr   = flash_mp_pkg::OpBankErase;
  localparam flash_mp_pkg::flash_part_e   Dat    = flash_mp_pkg::PartData;
  localparam flash_mp_pkg::flash_part_e   Inf    = flash_mp_pkg::PartInfo;
  localparam flash_geom_pkg::flash_word_t Erased = 16'hffff;

  typedef struct packed {
    flash_mp_pkg::flash_op_e           op;
    flash_mp_pkg::flash_part_e         part;
    flash_geom_pkg::flash_addr_u       addr;
    logic [1:0]                        len;
    flash_geom_pkg::flash_word_t       wdata;
    // hold start high for two more cycles while busy
    logic                              poke;
    logic                              exp_err;
    flash_geom_pkg::flash_addr_u       exp_err_addr;
    flash_geom_pkg::flash_word_t [0:3] exp_rd;
  } row_t;

  logic                                         clk;
  logic                                         rst_n;
  logic                                         start;
  flash_mp_pkg::flash_op_e                      op;
  flash_mp_pkg::flash_part_e                    part;
  flash_geom_pkg::flash_addr_u                  addr;
  logic [1:0]                                   len;
  flash_geom_pkg::flash_word_t                  wdata;
  logic                                         busy;
  logic                                         cmd_done;
  logic                                         cmd_err;
  logic                                         rvalid;
  flash_mp_pkg::mp_region_cfg_t [MpRegions-1:0] region_cfgs;
  flash_mp_pkg::mp_region_cfg_t                 default_cfg;
  flash_mp_pkg::mp_attr_t
    [flash_geom_pkg::NumBanks-1:0][flash_geom_pkg::InfoPagesPerBank-1:0] info_cfgs;
  logic [flash_geom_pkg::NumBanks-1:0]          bank_erase_en;
  flash_geom_pkg::flash_word_t                  rdata;
  flash_geom_pkg::flash_addr_u                  err_addr;

  row_t rows[$];
  int   cycle_cnt   = 0;
  int   cycle_limit = 0;

  tb_clk_gen #(.PeriodNs(8), .ResetCycles(2)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  flash_prot_top #(
    .MpRegions(MpRegions)
  ) dut0 (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .start_i         (start),
    .op_i            (op),
    .part_i          (part),
    .addr_i          (addr),
    .len_i           (len),
    .wdata_i         (wdata),
    .busy_o          (busy),
    .cmd_done_o      (cmd_done),
    .cmd_err_o       (cmd_err),
    .rvalid_o        (rvalid),
    .region_cfgs_i   (region_cfgs),
    .default_cfg_i   (default_cfg),
    .info_cfgs_i     (info_cfgs),
    .bank_erase_en_i (bank_erase_en),
    .rdata_o         (rdata),
    .err_addr_o      (err_addr)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("the run went past its limit of %0d cycles, a command never finished",
               cycle_limit);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////////////
  // address and attribute builders
  ////////////////////////////////////////////////////////////
  function automatic flash_mp_pkg::mp_attr_t perm(input logic en, input logic rd,
                                                  input logic pg, input logic er);
    flash_mp_pkg::mp_attr_t a;
    a.en       = en;
    a.rd_en    = rd;
    a.prog_en  = pg;
    a.erase_en = er;
    return a;
  endfunction

  function automatic flash_geom_pkg::flash_addr_u data_addr(input int bank, input int page,
                                                            input int word);
    flash_geom_pkg::flash_addr_u a;
    a.data.bank = bank[0];
    a.data.page = page[2:0];
    a.data.word = word[1:0];
    return a;
  endfunction

  function automatic flash_geom_pkg::flash_addr_u info_addr(input int bank, input int rsvd,
                                                            input int ipage, input int word);
    flash_geom_pkg::flash_addr_u a;
    a.info.bank      = bank[0];
    a.info.rsvd      = rsvd[1:0];
    a.info.info_page = ipage[0];
    a.info.word      = word[1:0];
    return a;
  endfunction

  function automatic void add_row(
    input flash_mp_pkg::flash_op_e           r_op,
    input flash_mp_pkg::flash_part_e         r_part,
    input flash_geom_pkg::flash_addr_u       r_addr,
    input logic [1:0]                        r_len,
    input flash_geom_pkg::flash_word_t       r_wdata,
    input logic                              r_poke,
    input logic                              r_err,
    input flash_geom_pkg::flash_addr_u       r_err_addr,
    input flash_geom_pkg::flash_word_t [0:3] r_rd
  );
    row_t r;
    r.op           = r_op;
    r.part         = r_part;
    r.addr         = r_addr;
    r.len          = r_len;
    r.wdata        = r_wdata;
    r.poke         = r_poke;
    r.exp_err      = r_err;
    r.exp_err_addr = r_err_addr;
    r.exp_rd       = r_rd;
    rows.push_back(r);
  endfunction

  ////////////////////////////////////////////////////////////
  // command table
  ////////////////////////////////////////////////////////////
  // op, part, addr, len, wdata, poke, err, err addr, read words
  function automatic void build_table();
    // program and read back in region 0
    add_row(Pg, Dat, data_addr(0, 0, 0), 2'd3, 16'ha5c3, 1'b0, 1'b0, '0, '0);
    add_row(Rd, Dat, data_addr(0, 0, 0), 2'd3, 16'h0, 1'b0, 1'b0, '0, {4{Erased & 16'ha5c3}});
    add_row(Pg, Dat, data_addr(0, 0, 1), 2'd0, 16'h0ff0, 1'b0, 1'b0, '0, '0);
    add_row(Rd, Dat, data_addr(0, 0, 0), 2'd1, 16'h0, 1'b0, 1'b0, '0,
            {Erased & 16'ha5c3, Erased & 16'ha5c3 & 16'h0ff0, 16'h0, 16'h0});
    // region 0 wins on page 2 and has no erase
    add_row(Pg, Dat, data_addr(0, 2, 0), 2'd1, 16'h1234, 1'b0, 1'b0, '0, '0);
    add_row(PgEr, Dat, data_addr(0, 2, 0), 2'd0, 16'h0, 1'b0, 1'b1, data_addr(0, 2, 0), '0);
    add_row(Rd, Dat, data_addr(0, 2, 0), 2'd1, 16'h0, 1'b0, 1'b0, '0,
            {Erased & 16'h1234, Erased & 16'h1234, 16'h0, 16'h0});
    // page 4 is only in region 1, which allows erase
    add_row(Pg, Dat, data_addr(0, 4, 0), 2'd3, 16'h00ff, 1'b0, 1'b0, '0, '0);
    add_row(Rd, Dat, data_addr(0, 4, 0), 2'd0, 16'h0, 1'b0, 1'b0, '0,
            {Erased & 16'h00ff, 16'h0, 16'h0, 16'h0});
    add_row(PgEr, Dat, data_addr(0, 4, 2), 2'd1, 16'h0, 1'b0, 1'b0, '0, '0);
    add_row(Rd, Dat, data_addr(0, 4, 0), 2'd3, 16'h0, 1'b0, 1'b0, '0, {4{Erased}});
    // no region, read-only info page, reserved bits set
    add_row(Rd, Dat, data_addr(1, 5, 1), 2'd0, 16'h0, 1'b0, 1'b1, data_addr(1, 5, 1), '0);
    add_row(Pg, Inf, info_addr(1, 0, 0, 0), 2'd0, 16'h0, 1'b0, 1'b1, info_addr(1, 0, 0, 0), '0);
    add_row(Rd, Inf, info_addr(1, 1, 0, 2), 2'd0, 16'h0, 1'b0, 1'b1, info_addr(1, 1, 0, 2), '0);
    add_row(Rd, Inf, info_addr(1, 0, 0, 0), 2'd1, 16'h0, 1'b0, 1'b0, '0,
            {Erased, Erased, 16'h0, 16'h0});
    // runs off the end of page 0 after two words
    add_row(Rd, Dat, data_addr(0, 0, 2), 2'd3, 16'h0, 1'b0, 1'b1, data_addr(0, 1, 0),
            {Erased & 16'ha5c3, Erased & 16'ha5c3, 16'h0, 16'h0});
    // bank erase is enabled on bank 1 data only
    add_row(Pg, Dat, data_addr(1, 1, 0), 2'd3, 16'h5a5a, 1'b0, 1'b0, '0, '0);
    add_row(Pg, Dat, data_addr(1, 3, 3), 2'd0, 16'hc3c3, 1'b0, 1'b0, '0, '0);
    add_row(Rd, Dat, data_addr(1, 1, 0), 2'd0, 16'h0, 1'b0, 1'b0, '0,
            {Erased & 16'h5a5a, 16'h0, 16'h0, 16'h0});
    add_row(BkEr, Dat, data_addr(0, 0, 0), 2'd0, 16'h0, 1'b0, 1'b1, data_addr(0, 0, 0), '0);
    add_row(BkEr, Inf, info_addr(1, 0, 0, 0), 2'd0, 16'h0, 1'b0, 1'b1,
            info_addr(1, 0, 0, 0), '0);
    add_row(Rd, Dat, data_addr(0, 0, 0), 2'd0, 16'h0, 1'b0, 1'b0, '0,
            {Erased & 16'ha5c3, 16'h0, 16'h0, 16'h0});
    add_row(BkEr, Dat, data_addr(1, 0, 0), 2'd0, 16'h0, 1'b0, 1'b0, '0, '0);
    add_row(Rd, Dat, data_addr(1, 1, 0), 2'd3, 16'h0, 1'b0, 1'b0, '0, {4{Erased}});
    add_row(Rd, Dat, data_addr(1, 3, 3), 2'd0, 16'h0, 1'b0, 1'b0, '0,
            {Erased, 16'h0, 16'h0, 16'h0});
    // second start while busy
    add_row(Rd, Dat, data_addr(0, 2, 0), 2'd1, 16'h0, 1'b1, 1'b0, '0,
            {Erased & 16'h1234, Erased & 16'h1234, 16'h0, 16'h0});
  endfunction

  // issued words count up to the denied one, one for an erase and len + 1 otherwise
  function automatic int expected_words(input row_t r);
    logic [5:0] diff;
    diff = r.exp_err_addr - r.addr;
    if (r.exp_err) begin
      return int'(diff) + 1;
    end else if (r.op == PgEr || r.op == BkEr) begin
      return 1;
    end
    return int'(r.len) + 1;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic check_word(input flash_geom_pkg::flash_word_t got,
                            input flash_geom_pkg::flash_word_t exp, input string what);
    if (got !== exp) begin
      report_error($sformatf("%s: read 0x%04h, expected 0x%04h", what, got, exp));
    end
  endtask

  task automatic check_err(input logic got_err, input flash_geom_pkg::flash_addr_u got_addr,
                           input logic exp_err, input flash_geom_pkg::flash_addr_u exp_addr,
                           input string what);
    if (got_err !== exp_err) begin
      report_error($sformatf("%s: cmd_err_o %b, expected %b", what, got_err, exp_err));
    end else if (exp_err && got_addr !== exp_addr) begin
      report_error($sformatf("%s: err_addr_o 0x%02h, expected 0x%02h", what,
                             got_addr, exp_addr));
    end
  endtask

  task automatic check_done_time(input int got, input int exp, input string what);
    if (got != exp) begin
      report_error($sformatf("%s: cmd_done_o after %0d cycles, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      report_error($sformatf("%s: %0d rvalid_o pulses, expected %0d", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one command
  ////////////////////////////////////////////////////////////
  task automatic run_row(input int idx);
    row_t  r;
    string tag;
    int    start_edge;
    int    n_words;
    int    n_reads;
    int    rv_cnt;
    bit    done_seen;
    r       = rows[idx];
    tag     = $sformatf("row %0d", idx);
    n_words = expected_words(r);
    n_reads = (r.op == Rd) ? n_words - int'(r.exp_err) : 0;
    @(posedge clk);
    #1;
    op    = r.op;
    part  = r.part;
    addr  = r.addr;
    len   = r.len;
    wdata = r.wdata;
    start = 1'b1;
    // cycle in which start is high
    start_edge = cycle_cnt;
    rv_cnt     = 0;
    done_seen  = 1'b0;
    while (!done_seen) begin
      @(posedge clk);
      #1;
      start = r.poke && (cycle_cnt < start_edge + 3);
      if (!busy) begin
        report_error($sformatf("%s: busy_o low while the command runs", tag));
      end
      if (rvalid) begin
        if (rv_cnt >= n_reads) begin
          report_error($sformatf("%s: unexpected rvalid_o", tag));
        end else begin
          check_word(rdata, r.exp_rd[rv_cnt], tag);
        end
        rv_cnt++;
      end
      if (cmd_done) begin
        done_seen = 1'b1;
      end
    end
    check_done_time(cycle_cnt - start_edge, 2 * n_words + 1, tag);
    check_err(cmd_err, err_addr, r.exp_err, r.exp_err_addr, tag);
    check_count(rv_cnt, n_reads, tag);
    // a second start accepted would show up here
    repeat (2) begin
      @(posedge clk);
      #1;
      if (busy || cmd_done) begin
        report_error($sformatf("%s: busy_o or cmd_done_o high after the command", tag));
      end
    end
  endtask

  initial begin
    start         = 1'b0;
    op            = Rd;
    part          = Dat;
    addr          = '0;
    len           = 2'd0;
    wdata         = '0;
    region_cfgs[0] = '{attr: perm(1'b1, 1'b1, 1'b1, 1'b0), base: 4'h0, size: 5'd4};
    region_cfgs[1] = '{attr: perm(1'b1, 1'b1, 1'b1, 1'b1), base: 4'h2, size: 5'd6};
    region_cfgs[2] = '{attr: perm(1'b1, 1'b1, 1'b1, 1'b0), base: 4'h8, size: 5'd4};
    default_cfg   = '0;
    info_cfgs     = '0;
    info_cfgs[1][0] = perm(1'b1, 1'b1, 1'b0, 1'b0);
    bank_erase_en = 2'b10;
    build_table();
    cycle_limit = rows.size() * 12 + 20;

    @(posedge rst_n);
    @(posedge clk);
    #1;
    if (busy || cmd_done || cmd_err || rvalid) begin
      report_error("status outputs not low after reset");
    end
    if (err_addr !== '0) begin
      report_error("err_addr_o not zero after reset");
    end

    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
// testbench clock and reset source
// free running clock, active-low reset held for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PeriodNs    = 8,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release just after an edge, like the rest of the stimulus
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/flash_prot_top.sv
// top level of the protected flash slice
// op FSM, address counter, protection check and array model
`timescale 1ns/1ps
`default_nettype none

module flash_prot_top #(
  parameter int MpRegions = 2
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         start_i,
  input  flash_mp_pkg::flash_op_e                      op_i,
  input  flash_mp_pkg::flash_part_e                    part_i,
  input  flash_geom_pkg::flash_addr_u                  addr_i,
  input  logic [1:0]                                   len_i,
  input  flash_geom_pkg::flash_word_t                  wdata_i,
  output logic                                         busy_o,
  output logic                                         cmd_done_o,
  output logic                                         cmd_err_o,
  output logic                                         rvalid_o,
  input  flash_mp_pkg::mp_region_cfg_t [MpRegions-1:0] region_cfgs_i,
  input  flash_mp_pkg::mp_region_cfg_t                 default_cfg_i,
  input  flash_mp_pkg::mp_attr_t
         [flash_geom_pkg::NumBanks-1:0][flash_geom_pkg::InfoPagesPerBank-1:0] info_cfgs_i,
  input  logic [flash_geom_pkg::NumBanks-1:0]          bank_erase_en_i,
  output flash_geom_pkg::flash_word_t                  rdata_o,
  output flash_geom_pkg::flash_addr_u                  err_addr_o
);

  logic                        cnt_load;
  logic                        cnt_step;
  flash_geom_pkg::flash_addr_u cnt_start;
  logic [1:0]                  cnt_len;
  flash_geom_pkg::flash_addr_u cnt_addr;
  logic                        cnt_ovfl;
  logic                        cnt_last;

  flash_cmd_if cmd_if ();
  flash_phy_if phy_if ();

  flash_op_fsm u_op_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .op_i        (op_i),
    .part_i      (part_i),
    .addr_i      (addr_i),
    .len_i       (len_i),
    .wdata_i     (wdata_i),
    .busy_o      (busy_o),
    .cmd_done_o  (cmd_done_o),
    .cmd_err_o   (cmd_err_o),
    .rvalid_o    (rvalid_o),
    .cnt_load_o  (cnt_load),
    .cnt_step_o  (cnt_step),
    .cnt_start_o (cnt_start),
    .cnt_len_o   (cnt_len),
    .cnt_addr_i  (cnt_addr),
    .cnt_ovfl_i  (cnt_ovfl),
    .cnt_last_i  (cnt_last),
    .cmd         (cmd_if.ctrl)
  );

  flash_addr_cnt u_addr_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (cnt_load),
    .step_i       (cnt_step),
    .start_addr_i (cnt_start),
    .len_i        (cnt_len),
    .addr_o       (cnt_addr),
    .ovfl_o       (cnt_ovfl),
    .last_o       (cnt_last)
  );

  flash_mp #(
    .MpRegions(MpRegions)
  ) u_mp (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .region_cfgs_i   (region_cfgs_i),
    .default_cfg_i   (default_cfg_i),
    .info_cfgs_i     (info_cfgs_i),
    .bank_erase_en_i (bank_erase_en_i),
    .cmd             (cmd_if.mp),
    .phy             (phy_if.mp)
  );

  flash_array u_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .phy    (phy_if.phy)
  );

  assign rdata_o    = phy_if.rdata;
  assign err_addr_o = cmd_if.err_addr;

endmodule

`default_nettype wire

//--- logic/flash_array.sv
// flash storage model, data and info partitions
// program only clears bits, erase sets a page or bank to ones
`timescale 1ns/1ps
`default_nettype none

module flash_array (
  input  logic    clk_i,
  input  logic    rst_ni,
  flash_phy_if.phy phy
);

  localparam int DataWords = flash_geom_pkg::NumBanks * flash_geom_pkg::PagesPerBank *
                             flash_geom_pkg::WordsPerPage;
  localparam int InfoWords = flash_geom_pkg::NumBanks * flash_geom_pkg::InfoPagesPerBank *
                             flash_geom_pkg::WordsPerPage;
  localparam int BankWords = flash_geom_pkg::PagesPerBank * flash_geom_pkg::WordsPerPage;

  flash_geom_pkg::flash_word_t data_mem [DataWords];
  flash_geom_pkg::flash_word_t info_mem [InfoWords];
  logic [5:0]                  didx;
  logic [3:0]                  iidx;
  logic                        is_info;
  logic                        done_q;
  flash_geom_pkg::flash_word_t rdata_q;

  assign didx    = phy.addr;
  assign iidx    = {phy.addr.info.bank, phy.addr.info.info_page, phy.addr.info.word};
  assign is_info = (phy.part == flash_mp_pkg::PartInfo);

  // a fresh device reads as all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DataWords; i++) data_mem[i] <= '1;
      for (int i = 0; i < InfoWords; i++) info_mem[i] <= '1;
    end else if (phy.prog) begin
      if (is_info) begin
        info_mem[iidx] <= info_mem[iidx] & phy.wdata;
      end else begin
        data_mem[didx] <= data_mem[didx] & phy.wdata;
      end
    end else if (phy.pg_erase) begin
      for (int w = 0; w < flash_geom_pkg::WordsPerPage; w++) begin
        if (is_info) begin
          info_mem[{iidx[3:2], 2'(w)}] <= '1;
        end else begin
          data_mem[{didx[5:2], 2'(w)}] <= '1;
        end
      end
    end else if (phy.bk_erase) begin
      for (int i = 0; i < BankWords; i++) begin
        data_mem[{phy.addr.data.bank, 5'(i)}] <= '1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= phy.req;
    end
  end

  // read word is held until the next read
  always_ff @(posedge clk_i) begin
    if (phy.rd) begin
      rdata_q <= is_info ? info_mem[iidx] : data_mem[didx];
    end
  end

  assign phy.done  = done_q;
  assign phy.rdata = rdata_q;

endmodule

`default_nettype wire

//--- logic/flash_mp.sv
// memory protection check per word
// data partition uses software regions, info partition uses
// per-page attributes; denied words return a registered error
`timescale 1ns/1ps
`default_nettype none

module flash_mp #(
  parameter int MpRegions = 2
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  flash_mp_pkg::mp_region_cfg_t [MpRegions-1:0] region_cfgs_i,
  input  flash_mp_pkg::mp_region_cfg_t                 default_cfg_i,
  input  flash_mp_pkg::mp_attr_t
         [flash_geom_pkg::NumBanks-1:0][flash_geom_pkg::InfoPagesPerBank-1:0] info_cfgs_i,
  input  logic [flash_geom_pkg::NumBanks-1:0]          bank_erase_en_i,
  flash_cmd_if.mp                                      cmd,
  flash_phy_if.mp                                      phy
);

  flash_geom_pkg::flash_page_t data_page;
  flash_mp_pkg::mp_attr_t      data_attr;
  flash_mp_pkg::mp_attr_t      info_attr;
  flash_mp_pkg::mp_attr_t      attr;
  logic                        is_data;
  logic                        rsvd_bad;
  logic                        op_ok;
  logic                        pass;
  logic                        deny;
  logic                        err_q;
  flash_geom_pkg::flash_addr_u err_addr_q;

  ////////////////////////////////////////////////////////////
  // attribute lookup
  ////////////////////////////////////////////////////////////
  assign is_data   = (cmd.part == flash_mp_pkg::PartData);
  assign data_page = {cmd.addr.data.bank, cmd.addr.data.page};

  flash_mp_region_sel #(
    .Regions(MpRegions)
  ) u_region_sel (
    .req_i      (cmd.req & is_data),
    .page_i     (data_page),
    .regions_i  (region_cfgs_i),
    .default_i  (default_cfg_i),
    .sel_attr_o (data_attr)
  );

  assign info_attr = info_cfgs_i[cmd.addr.info.bank][cmd.addr.info.info_page];
  assign attr      = is_data ? data_attr : info_attr;
  assign rsvd_bad  = !is_data && (cmd.addr.info.rsvd != 2'b00);

  // bank erase ignores regions, only the per-bank enable counts
  always_comb begin
    case (cmd.op)
      flash_mp_pkg::OpRead:      op_ok = attr.en & attr.rd_en;
      flash_mp_pkg::OpProg:      op_ok = attr.en & attr.prog_en;
      flash_mp_pkg::OpPageErase: op_ok = attr.en & attr.erase_en;
      flash_mp_pkg::OpBankErase: op_ok = is_data & bank_erase_en_i[cmd.addr.data.bank];
      default:                   op_ok = 1'b0;
    endcase
  end

  assign pass = cmd.req & op_ok & ~rsvd_bad & ~cmd.ovfl;
  assign deny = cmd.req & ~pass;

  ////////////////////////////////////////////////////////////
  // requests to the array
  ////////////////////////////////////////////////////////////
  assign phy.req      = pass;
  assign phy.rd       = pass & (cmd.op == flash_mp_pkg::OpRead);
  assign phy.prog     = pass & (cmd.op == flash_mp_pkg::OpProg);
  assign phy.pg_erase = pass & (cmd.op == flash_mp_pkg::OpPageErase);
  assign phy.bk_erase = pass & (cmd.op == flash_mp_pkg::OpBankErase);
  assign phy.part     = cmd.part;
  assign phy.addr     = cmd.addr;
  assign phy.wdata    = cmd.wdata;

  // error comes back one cycle after the denied request,
  // same as a done from the array
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q      <= 1'b0;
      err_addr_q <= '0;
    end else begin
      err_q <= deny;
      if (deny) begin
        err_addr_q <= cmd.addr;
      end
    end
  end

  assign cmd.done     = phy.done | err_q;
  assign cmd.err      = err_q;
  assign cmd.err_addr = err_addr_q;

endmodule

`default_nettype wire

//--- logic/flash_mp_region_sel.sv
// data region selection
// lowest-indexed enabled region covering the page wins,
// default attributes otherwise
`timescale 1ns/1ps
`default_nettype none

module flash_mp_region_sel #(
  parameter int Regions = 2
) (
  input  logic                                       req_i,
  input  flash_geom_pkg::flash_page_t                page_i,
  input  flash_mp_pkg::mp_region_cfg_t [Regions-1:0] regions_i,
  input  flash_mp_pkg::mp_region_cfg_t               default_i,
  output flash_mp_pkg::mp_attr_t                     sel_attr_o
);

  logic [Regions-1:0] hit;

  // 6 bits so base plus size cannot wrap
  always_comb begin
    for (int i = 0; i < Regions; i++) begin
      hit[i] = regions_i[i].attr.en &&
               (6'(page_i) >= 6'(regions_i[i].base)) &&
               (6'(page_i) < 6'(regions_i[i].base) + 6'(regions_i[i].size));
    end
  end

  // walk downwards so the lowest index is applied last
  always_comb begin
    sel_attr_o = default_i.attr;
    for (int i = Regions - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel_attr_o = regions_i[i].attr;
      end
    end
    if (!req_i) begin
      sel_attr_o = '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/flash_addr_cnt.sv
// word address counter with remaining count
// flags a command that steps past the end of its page
`timescale 1ns/1ps
`default_nettype none

module flash_addr_cnt (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        load_i,
  input  logic                        step_i,
  input  flash_geom_pkg::flash_addr_u start_addr_i,
  input  logic [1:0]                  len_i,
  output flash_geom_pkg::flash_addr_u addr_o,
  output logic                        ovfl_o,
  output logic                        last_o
);

  flash_geom_pkg::flash_addr_u         addr_q;
  logic [flash_geom_pkg::AddrW-1:0]    addr_next;
  logic [1:0]                          remain_q;
  logic                                ovfl_q;

  // full address increments, so the word after a page end is the next page
  assign addr_next = addr_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      remain_q <= '0;
      ovfl_q   <= 1'b0;
    end else if (load_i) begin
      addr_q   <= start_addr_i;
      remain_q <= len_i;
      ovfl_q   <= 1'b0;
    end else if (step_i) begin
      addr_q   <= addr_next;
      remain_q <= remain_q - 1'b1;
      // sticky until the next load
      if (&addr_q.data.word) begin
        ovfl_q <= 1'b1;
      end
    end
  end

  assign addr_o = addr_q;
  assign ovfl_o = ovfl_q;
  assign last_o = (remain_q == 2'd0);

endmodule

`default_nettype wire

//--- logic/flash_op_fsm.sv
// command sequencing FSM
// latches a command, loads the address counter and issues
// one protected request per word until the last word or an error
`timescale 1ns/1ps
`default_nettype none

module flash_op_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  flash_mp_pkg::flash_op_e     op_i,
  input  flash_mp_pkg::flash_part_e   part_i,
  input  flash_geom_pkg::flash_addr_u addr_i,
  input  logic [1:0]                  len_i,
  input  flash_geom_pkg::flash_word_t wdata_i,
  output logic                        busy_o,
  output logic                        cmd_done_o,
  output logic                        cmd_err_o,
  output logic                        rvalid_o,
  output logic                        cnt_load_o,
  output logic                        cnt_step_o,
  output flash_geom_pkg::flash_addr_u cnt_start_o,
  output logic [1:0]                  cnt_len_o,
  input  flash_geom_pkg::flash_addr_u cnt_addr_i,
  input  logic                        cnt_ovfl_i,
  input  logic                        cnt_last_i,
  flash_cmd_if.ctrl                   cmd
);

  typedef enum logic [1:0] {Idle, Issue, Wait, Finish} state_e;

  state_e                      state_q;
  state_e                      state_d;
  flash_mp_pkg::flash_op_e     op_q;
  flash_mp_pkg::flash_part_e   part_q;
  flash_geom_pkg::flash_word_t wdata_q;
  logic                        err_q;
  logic                        is_erase;

  // an erase is a single request whatever the length says
  assign is_erase    = (op_i == flash_mp_pkg::OpPageErase) ||
                       (op_i == flash_mp_pkg::OpBankErase);
  assign cnt_start_o = addr_i;
  assign cnt_len_o   = is_erase ? 2'd0 : len_i;

  always_comb begin
    state_d    = state_q;
    cnt_load_o = 1'b0;
    cnt_step_o = 1'b0;
    case (state_q)
      Idle: begin
        if (start_i) begin
          cnt_load_o = 1'b1;
          state_d    = Issue;
        end
      end
      Issue: state_d = Wait;
      Wait: begin
        if (cmd.done) begin
          if (cmd.err || cnt_last_i) begin
            state_d = Finish;
          end else begin
            cnt_step_o = 1'b1;
            state_d    = Issue;
          end
        end
      end
      Finish: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      op_q    <= flash_mp_pkg::OpRead;
      part_q  <= flash_mp_pkg::PartData;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (cnt_load_o) begin
        op_q   <= op_i;
        part_q <= part_i;
        err_q  <= 1'b0;
      end else if (state_q == Wait && cmd.done) begin
        err_q <= cmd.err;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cnt_load_o) begin
      wdata_q <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // request and status outputs
  ////////////////////////////////////////////////////////////
  assign cmd.req   = (state_q == Issue);
  assign cmd.op    = op_q;
  assign cmd.part  = part_q;
  assign cmd.addr  = cnt_addr_i;
  assign cmd.ovfl  = cnt_ovfl_i;
  assign cmd.wdata = wdata_q;

  assign busy_o     = (state_q != Idle);
  assign cmd_done_o = (state_q == Finish);
  assign cmd_err_o  = cmd_done_o & err_q;
  assign rvalid_o   = (state_q == Wait) & cmd.done & ~cmd.err &
                      (op_q == flash_mp_pkg::OpRead);

endmodule

`default_nettype wire

//--- logic/flash_ifs.sv
// flash_cmd_if: per-word request from the op FSM to protection
// flash_phy_if: checked request from protection to the array
`timescale 1ns/1ps
`default_nettype none

interface flash_cmd_if;

  logic                          req;
  flash_mp_pkg::flash_op_e       op;
  flash_mp_pkg::flash_part_e     part;
  flash_geom_pkg::flash_addr_u   addr;
  logic                          ovfl;
  flash_geom_pkg::flash_word_t   wdata;
  logic                          done;
  logic                          err;
  flash_geom_pkg::flash_addr_u   err_addr;

  modport ctrl (output req, op, part, addr, ovfl, wdata,
                input  done, err, err_addr);

  modport mp (input  req, op, part, addr, ovfl, wdata,
              output done, err, err_addr);

endinterface

interface flash_phy_if;

  logic                          req;
  logic                          rd;
  logic                          prog;
  logic                          pg_erase;
  logic                          bk_erase;
  // selects data or info storage
  flash_mp_pkg::flash_part_e     part;
  flash_geom_pkg::flash_addr_u   addr;
  flash_geom_pkg::flash_word_t   wdata;
  logic                          done;
  flash_geom_pkg::flash_word_t   rdata;

  modport mp (output req, rd, prog, pg_erase, bk_erase, part, addr, wdata,
              input  done, rdata);

  modport phy (input  req, rd, prog, pg_erase, bk_erase, part, addr, wdata,
               output done, rdata);

endinterface

`default_nettype wire

//--- logic/flash_mp_pkg.sv
// memory protection types
// operation and partition enums, attribute bits, region config
`default_nettype none

package flash_mp_pkg;

  typedef enum logic [1:0] {
    OpRead      = 2'd0,
    OpProg      = 2'd1,
    OpPageErase = 2'd2,
    OpBankErase = 2'd3
  } flash_op_e;

  typedef enum logic {
    PartData = 1'b0,
    PartInfo = 1'b1
  } flash_part_e;

  // en gates the other three bits
  typedef struct packed {
    logic en;
    logic rd_en;
    logic prog_en;
    logic erase_en;
  } mp_attr_t;

  // region covers pages base .. base+size-1 in bank-and-page space
  typedef struct packed {
    mp_attr_t                  attr;
    flash_geom_pkg::flash_page_t base;
    logic [4:0]                size;
  } mp_region_cfg_t;

endpackage

`default_nettype wire

//--- logic/flash_geom_pkg.sv
// flash geometry constants
// data word type, bank-and-page index type
// address union with a data view and an info view
`default_nettype none

package flash_geom_pkg;

  localparam int NumBanks         = 2;
  localparam int PagesPerBank     = 8;
  localparam int WordsPerPage     = 4;
  localparam int InfoPagesPerBank = 2;

  localparam int AddrW = 6;

  typedef logic [15:0] flash_word_t;

  // bank and page, used by region base and size
  typedef logic [3:0] flash_page_t;

  typedef struct packed {
    logic       bank;
    logic [2:0] page;
    logic [1:0] word;
  } flash_data_addr_t;

  // reserved bits have to be zero for a legal info access
  typedef struct packed {
    logic       bank;
    logic [1:0] rsvd;
    logic       info_page;
    logic [1:0] word;
  } flash_info_addr_t;

  typedef union packed {
    flash_data_addr_t data;
    flash_info_addr_t info;
  } flash_addr_u;

endpackage

`default_nettype wire
